/* hdl/bridge_params.svh */
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

`define BRIDGE_WORD_W          32
`define BRIDGE_PADDR_W         32
`define BRIDGE_CSR_ADDR_W      4

//////////////////////////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////////////////////////

// processor view of dram starts here
`define BRIDGE_DRAM_BASE       32'h8000_0000

// local addresses carry a tile and a device field
`define BRIDGE_TILE_LSB        24
`define BRIDGE_TILE_W          6
`define BRIDGE_DEV_LSB         20
`define BRIDGE_DEV_W           4
`define BRIDGE_HOST_DEV        1
`define BRIDGE_MY_TILE         0

// host request credits and response queue
`define BRIDGE_CREDITS_MAX     32
`define BRIDGE_CREDIT_W        6
`define BRIDGE_HOSTQ_DEPTH     8

`endif

/* hdl/csr_pkg.sv */
`default_nettype none

`include "bridge_params.svh"

package csr_pkg;

   // index and value of a host register
   typedef logic [`BRIDGE_CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [`BRIDGE_WORD_W-1:0]     csr_data_t;

   //////////////////////////////////////////////////////////////////////
   // register map
   //////////////////////////////////////////////////////////////////////

   // CTRL bit 0 is the system reset, low true
   // CREDITS is read only
   typedef enum csr_addr_t
   {
      CSR_CTRL      = csr_addr_t'(0),
      CSR_DRAM_BASE = csr_addr_t'(1),
      CSR_CREDITS   = csr_addr_t'(2)
   } csr_reg_e;

   // one host access, a read when we is low
   typedef struct packed
   {
      csr_addr_t addr;
      logic      we;
      csr_data_t wdata;
   } csr_cmd_s;

endpackage

`default_nettype wire

/* hdl/mem_pkg.sv */
`default_nettype none

`include "bridge_params.svh"

package mem_pkg;

   // physical address and data word of a memory message
   typedef logic [`BRIDGE_PADDR_W-1:0]  paddr_t;
   typedef logic [`BRIDGE_WORD_W-1:0]   word_t;

   // number of host requests still waiting for a response
   typedef logic [`BRIDGE_CREDIT_W-1:0] credit_t;

   //////////////////////////////////////////////////////////////////////
   // endpoints
   //////////////////////////////////////////////////////////////////////

   // names the far side of the bridge
   // the router uses it as a destination and the merge as a source tag
   typedef enum logic
   {
      MEM_SRC_DRAM = 1'b0,
      MEM_SRC_HOST = 1'b1
   } mem_src_e;

   //////////////////////////////////////////////////////////////////////
   // messages
   //////////////////////////////////////////////////////////////////////

   // request from the processor, single word
   typedef struct packed
   {
      paddr_t addr;
      word_t  data;
      logic   we;
   } mem_req_s;

   // response back to the processor
   typedef struct packed
   {
      word_t    data;
      mem_src_e src;
   } mem_rsp_s;

endpackage

`default_nettype wire

/* hdl/csr_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_bank
  (
   input  wire                  aclk_i
   , input  wire                rst_i

   // host register port
   , input  wire                csr_cmd_v_i
   , input  wire csr_pkg::csr_cmd_s csr_cmd_i
   , output logic               csr_rd_v_o
   , output csr_pkg::csr_data_t csr_rd_data_o

   // status in, control out
   , input  wire mem_pkg::credit_t credits_i
   , output mem_pkg::paddr_t    dram_base_o
   , output logic               dp_rst_o
   );

   csr_pkg::csr_data_t ctrl_r;
   mem_pkg::paddr_t    dram_base_r;
   csr_pkg::csr_data_t rd_mux;
   logic               wr_v;
   logic               rd_v;

   assign wr_v = csr_cmd_v_i & csr_cmd_i.we;
   assign rd_v = csr_cmd_v_i & ~csr_cmd_i.we;

   //////////////////////////////////////////////////////////////////////
   // register writes
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
      begin
         ctrl_r      <= '0;
         dram_base_r <= '0;
      end
      else if (wr_v)
      begin
         case (csr_cmd_i.addr)
            csr_pkg::CSR_CTRL:      ctrl_r      <= csr_cmd_i.wdata;
            csr_pkg::CSR_DRAM_BASE: dram_base_r <= csr_cmd_i.wdata;
            // credits and unused indexes have no storage
            default: ;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // register reads
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (csr_cmd_i.addr)
         csr_pkg::CSR_CTRL:      rd_mux = ctrl_r;
         csr_pkg::CSR_DRAM_BASE: rd_mux = csr_pkg::csr_data_t'(dram_base_r);
         csr_pkg::CSR_CREDITS:   rd_mux = csr_pkg::csr_data_t'(credits_i);
         default:                rd_mux = '0;
      endcase
   end

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
         csr_rd_v_o <= 1'b0;
      else
         csr_rd_v_o <= rd_v;
   end

   // value sampled at the read strobe
   always_ff @(posedge aclk_i)
   begin
      if (rd_v)
         csr_rd_data_o <= rd_mux;
   end

   assign dram_base_o = dram_base_r;

   // ctrl bit 0 low holds the whole datapath in reset
   assign dp_rst_o = rst_i | ~ctrl_r[0];

endmodule

`default_nettype wire

/* hdl/mem_fwd_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module mem_fwd_router
  (
   input  wire                  aclk_i
   , input  wire                rst_i

   // processor side
   , input  wire                proc_req_v_i
   , input  wire mem_pkg::mem_req_s proc_req_i
   , input  wire mem_pkg::paddr_t   dram_base_i

   // host and dram sides
   , output logic               host_req_v_o
   , output mem_pkg::mem_req_s  host_req_o
   , output logic               dram_req_v_o
   , output mem_pkg::mem_req_s  dram_req_o
   );

   typedef logic [`BRIDGE_TILE_W-1:0] tile_id_t;
   typedef logic [`BRIDGE_DEV_W-1:0]  dev_id_t;

   localparam tile_id_t        my_tile_lp   = tile_id_t'(`BRIDGE_MY_TILE);
   localparam dev_id_t         host_dev_lp  = dev_id_t'(`BRIDGE_HOST_DEV);
   localparam mem_pkg::paddr_t dram_base_lp = `BRIDGE_DRAM_BASE;

   tile_id_t          req_tile;
   dev_id_t           req_dev;
   logic              is_local;
   mem_pkg::mem_src_e dst;
   logic              host_sel;
   logic              dram_sel;
   mem_pkg::mem_req_s dram_req;

   //////////////////////////////////////////////////////////////////////
   // destination decode
   //////////////////////////////////////////////////////////////////////

   assign req_tile = proc_req_i.addr[`BRIDGE_TILE_LSB +: `BRIDGE_TILE_W];
   assign req_dev  = proc_req_i.addr[`BRIDGE_DEV_LSB +: `BRIDGE_DEV_W];
   assign is_local = (proc_req_i.addr < dram_base_lp);

   // only the host device of this tile leaves through the host port
   assign dst = (is_local && req_tile == my_tile_lp && req_dev == host_dev_lp)
                ? mem_pkg::MEM_SRC_HOST : mem_pkg::MEM_SRC_DRAM;

   assign host_sel = proc_req_v_i & (dst == mem_pkg::MEM_SRC_HOST);
   assign dram_sel = proc_req_v_i & (dst == mem_pkg::MEM_SRC_DRAM);

   // move from processor dram space into the region the host allocated
   always_comb
   begin
      dram_req      = proc_req_i;
      dram_req.addr = (proc_req_i.addr ^ dram_base_lp) + dram_base_i;
   end

   //////////////////////////////////////////////////////////////////////
   // output registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
      begin
         host_req_v_o <= 1'b0;
         dram_req_v_o <= 1'b0;
      end
      else
      begin
         host_req_v_o <= host_sel;
         dram_req_v_o <= dram_sel;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (host_sel)
         host_req_o <= proc_req_i;
      if (dram_sel)
         dram_req_o <= dram_req;
   end

endmodule

`default_nettype wire

/* hdl/host_credit_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module host_credit_tracker
  (
   input  wire                 aclk_i
   , input  wire               rst_i

   // host request issued, host response returned
   , input  wire               host_req_v_i
   , input  wire               host_rsp_v_i

   , output mem_pkg::credit_t  credits_o
   );

   localparam mem_pkg::credit_t max_lp = mem_pkg::credit_t'(`BRIDGE_CREDITS_MAX);

   logic inc;
   logic dec;

   // a request and a response together leave the count alone
   assign inc = host_req_v_i & ~host_rsp_v_i & (credits_o != max_lp);
   assign dec = host_rsp_v_i & ~host_req_v_i & (credits_o != '0);

   //////////////////////////////////////////////////////////////////////
   // saturating up/down counter
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
         credits_o <= '0;
      else if (inc)
         credits_o <= credits_o + 1'b1;
      else if (dec)
         credits_o <= credits_o - 1'b1;
   end

endmodule

`default_nettype wire

/* hdl/mem_rev_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module mem_rev_merge
  (
   input  wire                  aclk_i
   , input  wire                rst_i

   // responses from dram and host
   , input  wire                dram_rsp_v_i
   , input  wire mem_pkg::word_t dram_rsp_i
   , input  wire                host_rsp_v_i
   , input  wire mem_pkg::word_t host_rsp_i

   // merged stream to the processor
   , output logic               proc_rsp_v_o
   , output mem_pkg::mem_rsp_s  proc_rsp_o
   );

   localparam int depth_lp = `BRIDGE_HOSTQ_DEPTH;
   localparam int ptr_w_lp = $clog2(depth_lp);
   localparam int cnt_w_lp = $clog2(depth_lp + 1);

   typedef logic [ptr_w_lp-1:0] qptr_t;
   typedef logic [cnt_w_lp-1:0] qcnt_t;

   mem_pkg::word_t    q_mem [depth_lp];
   qptr_t             rd_ptr_r;
   qptr_t             wr_ptr_r;
   qcnt_t             count_r;
   logic              q_empty;
   logic              q_full;
   logic              pop;
   logic              push;
   logic              host_direct;
   logic              pick_v;
   mem_pkg::mem_rsp_s pick;

   function automatic qptr_t ptr_inc(qptr_t p);
      return (p == qptr_t'(depth_lp - 1)) ? '0 : p + 1'b1;
   endfunction

   assign q_empty = (count_r == '0);
   assign q_full  = (count_r == qcnt_t'(depth_lp));

   //////////////////////////////////////////////////////////////////////
   // fixed priority: dram, then queued host, then arriving host
   //////////////////////////////////////////////////////////////////////

   assign pop         = ~dram_rsp_v_i & ~q_empty;
   assign host_direct = host_rsp_v_i & ~dram_rsp_v_i & q_empty;
   assign pick_v      = dram_rsp_v_i | ~q_empty | host_rsp_v_i;

   // host responses that lose go to the queue
   assign push = host_rsp_v_i & ~host_direct & (~q_full | pop);

   always_comb
   begin
      if (dram_rsp_v_i)
         pick.data = dram_rsp_i;
      else if (!q_empty)
         pick.data = q_mem[rd_ptr_r];
      else
         pick.data = host_rsp_i;
      pick.src = dram_rsp_v_i ? mem_pkg::MEM_SRC_DRAM : mem_pkg::MEM_SRC_HOST;
   end

   //////////////////////////////////////////////////////////////////////
   // host response queue
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
      begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (pop)
            rd_ptr_r <= ptr_inc(rd_ptr_r);
         if (push)
            wr_ptr_r <= ptr_inc(wr_ptr_r);
         count_r <= count_r + qcnt_t'(push) - qcnt_t'(pop);
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (push)
         q_mem[wr_ptr_r] <= host_rsp_i;
   end

   // output stage
   always_ff @(posedge aclk_i)
   begin
      if (rst_i)
         proc_rsp_v_o <= 1'b0;
      else
         proc_rsp_v_o <= pick_v;
   end

   always_ff @(posedge aclk_i)
   begin
      if (pick_v)
         proc_rsp_o <= pick;
   end

endmodule

`default_nettype wire

/* hdl/zynq_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module zynq_bridge_top
  (
   input  wire                      aclk_i
   , input  wire                    rst_i

   // host register port
   , input  wire                    csr_cmd_v_i
   , input  wire csr_pkg::csr_cmd_s csr_cmd_i
   , output wire                    csr_rd_v_o
   , output wire csr_pkg::csr_data_t csr_rd_data_o

   // processor side
   , input  wire                    proc_req_v_i
   , input  wire mem_pkg::mem_req_s proc_req_i
   , output wire                    proc_rsp_v_o
   , output wire mem_pkg::mem_rsp_s proc_rsp_o

   // host memory port
   , output wire                    host_req_v_o
   , output wire mem_pkg::mem_req_s host_req_o
   , input  wire                    host_rsp_v_i
   , input  wire mem_pkg::word_t    host_rsp_i

   // dram port
   , output wire                    dram_req_v_o
   , output wire mem_pkg::mem_req_s dram_req_o
   , input  wire                    dram_rsp_v_i
   , input  wire mem_pkg::word_t    dram_rsp_i
   );

   logic             dp_rst;
   mem_pkg::paddr_t  dram_base;
   mem_pkg::credit_t credits;

   //////////////////////////////////////////////////////////////////////
   // control
   //////////////////////////////////////////////////////////////////////

   csr_bank csr
     (.aclk_i(aclk_i)
      ,.rst_i(rst_i)
      ,.csr_cmd_v_i(csr_cmd_v_i)
      ,.csr_cmd_i(csr_cmd_i)
      ,.csr_rd_v_o(csr_rd_v_o)
      ,.csr_rd_data_o(csr_rd_data_o)
      ,.credits_i(credits)
      ,.dram_base_o(dram_base)
      ,.dp_rst_o(dp_rst)
      );

   //////////////////////////////////////////////////////////////////////
   // datapath, all under the soft reset
   //////////////////////////////////////////////////////////////////////

   mem_fwd_router fwd_router
     (.aclk_i(aclk_i)
      ,.rst_i(dp_rst)
      ,.proc_req_v_i(proc_req_v_i)
      ,.proc_req_i(proc_req_i)
      ,.dram_base_i(dram_base)
      ,.host_req_v_o(host_req_v_o)
      ,.host_req_o(host_req_o)
      ,.dram_req_v_o(dram_req_v_o)
      ,.dram_req_o(dram_req_o)
      );

   host_credit_tracker credit_tracker
     (.aclk_i(aclk_i)
      ,.rst_i(dp_rst)
      ,.host_req_v_i(host_req_v_o)
      ,.host_rsp_v_i(host_rsp_v_i)
      ,.credits_o(credits)
      );

   mem_rev_merge rev_merge
     (.aclk_i(aclk_i)
      ,.rst_i(dp_rst)
      ,.dram_rsp_v_i(dram_rsp_v_i)
      ,.dram_rsp_i(dram_rsp_i)
      ,.host_rsp_v_i(host_rsp_v_i)
      ,.host_rsp_i(host_rsp_i)
      ,.proc_rsp_v_o(proc_rsp_v_o)
      ,.proc_rsp_o(proc_rsp_o)
      );

endmodule

`default_nettype wire

/* bench/bridge_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module bridge_checker
  (
   input  wire                       aclk_i
   , input  wire                     rst_i
   , input  wire [2:0]               test_id_i

   // everything the bench drives and the DUT returns
   , input  wire                     csr_cmd_v_i
   , input  wire csr_pkg::csr_cmd_s  csr_cmd_i
   , input  wire                     csr_rd_v_i
   , input  wire csr_pkg::csr_data_t csr_rd_data_i
   , input  wire                     proc_req_v_i
   , input  wire mem_pkg::mem_req_s  proc_req_i
   , input  wire                     host_req_v_i
   , input  wire mem_pkg::mem_req_s  host_req_i
   , input  wire                     dram_req_v_i
   , input  wire mem_pkg::mem_req_s  dram_req_i
   , input  wire                     host_rsp_v_i
   , input  wire mem_pkg::word_t     host_rsp_i
   , input  wire                     dram_rsp_v_i
   , input  wire mem_pkg::word_t     dram_rsp_i
   , input  wire                     proc_rsp_v_i
   , input  wire mem_pkg::mem_rsp_s  proc_rsp_i

   , output int                      checks_o
   , output int                      errors_o
   , output logic                    idle_o
   , output int                      hostq_level_o
   );

   typedef logic [`BRIDGE_TILE_W-1:0] tile_t;
   typedef logic [`BRIDGE_DEV_W-1:0]  dev_t;

   // model state, valid between a falling edge and the next rising edge
   csr_pkg::csr_data_t ctrl_m;
   mem_pkg::paddr_t    base_m;
   mem_pkg::credit_t   credits_m;
   mem_pkg::word_t     hostq_m[$];

   // what the DUT must show after the next rising edge
   logic               exp_rd_v;
   logic               exp_host_v;
   logic               exp_dram_v;
   logic               exp_rsp_v;
   csr_pkg::csr_data_t exp_rd;
   mem_pkg::mem_req_s  exp_host;
   mem_pkg::mem_req_s  exp_dram;
   mem_pkg::mem_rsp_s  exp_rsp;

   //////////////////////////////////////////////////////////////////////
   // reference functions
   //////////////////////////////////////////////////////////////////////

   function automatic logic goes_to_host(mem_pkg::paddr_t a);
      return (a < mem_pkg::paddr_t'(`BRIDGE_DRAM_BASE))
         && (a[`BRIDGE_TILE_LSB +: `BRIDGE_TILE_W] == tile_t'(`BRIDGE_MY_TILE))
         && (a[`BRIDGE_DEV_LSB +: `BRIDGE_DEV_W] == dev_t'(`BRIDGE_HOST_DEV));
   endfunction

   function automatic mem_pkg::paddr_t dram_addr(mem_pkg::paddr_t a, mem_pkg::paddr_t base);
      return (a ^ mem_pkg::paddr_t'(`BRIDGE_DRAM_BASE)) + base;
   endfunction

   function automatic mem_pkg::credit_t credit_next(mem_pkg::credit_t c, logic up, logic down);
      int n;
      n = int'(c);
      if (up != down)
         n = up ? n + 1 : n - 1;
      if (n > `BRIDGE_CREDITS_MAX)
         n = `BRIDGE_CREDITS_MAX;
      if (n < 0)
         n = 0;
      return mem_pkg::credit_t'(n);
   endfunction

   function automatic csr_pkg::csr_data_t csr_value(csr_pkg::csr_addr_t idx);
      case (idx)
         csr_pkg::CSR_CTRL:      return ctrl_m;
         csr_pkg::CSR_DRAM_BASE: return base_m;
         csr_pkg::CSR_CREDITS:   return csr_pkg::csr_data_t'(credits_m);
         default:                return '0;
      endcase
   endfunction

   // 0 nothing, 1 dram, 2 oldest queued host, 3 arriving host
   function automatic int merge_choice(logic dram_v, logic queued, logic host_v);
      if (dram_v)
         return 1;
      if (queued)
         return 2;
      if (host_v)
         return 3;
      return 0;
   endfunction

   function automatic string test_label(logic [2:0] id);
      case (id)
         3'd1:    return "register_access";
         3'd2:    return "soft_reset";
         3'd3:    return "routing";
         3'd4:    return "credits";
         3'd5:    return "response_merge";
         default: return "reset";
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // comparison
   //////////////////////////////////////////////////////////////////////

   task automatic compare(string what, logic exp_v, logic act_v,
                          logic [64:0] exp, logic [64:0] act);
      if (exp_v || act_v)
         checks_o++;
      if (exp_v !== act_v)
      begin
         errors_o++;
         $display("test %s: %s %s strobe", test_label(test_id_i),
                  exp_v ? "missing" : "unexpected", what);
      end
      else if (exp_v && exp !== act)
      begin
         errors_o++;
         $display("mismatch in test %s on %s: expected %0h, actual %0h",
                  test_label(test_id_i), what, exp, act);
      end
   endtask

   task automatic predict();
      logic dp;
      logic host_now;
      int   pick;
      dp       = rst_i | ~ctrl_m[0];
      host_now = exp_host_v;

      // reads see the registers before this edge updates them
      exp_rd_v = ~rst_i & csr_cmd_v_i & ~csr_cmd_i.we;
      exp_rd   = csr_value(csr_cmd_i.addr);

      exp_host_v    = ~dp & proc_req_v_i & goes_to_host(proc_req_i.addr);
      exp_dram_v    = ~dp & proc_req_v_i & ~goes_to_host(proc_req_i.addr);
      exp_host      = proc_req_i;
      exp_dram      = proc_req_i;
      exp_dram.addr = dram_addr(proc_req_i.addr, base_m);

      credits_m = dp ? '0 : credit_next(credits_m, host_now, host_rsp_v_i);

      exp_rsp_v = 1'b0;
      if (dp)
         hostq_m.delete();
      else
      begin
         pick      = merge_choice(dram_rsp_v_i, hostq_m.size() != 0, host_rsp_v_i);
         exp_rsp_v = (pick != 0);
         case (pick)
            1: exp_rsp = '{data: dram_rsp_i, src: mem_pkg::MEM_SRC_DRAM};
            2: exp_rsp = '{data: hostq_m.pop_front(), src: mem_pkg::MEM_SRC_HOST};
            3: exp_rsp = '{data: host_rsp_i, src: mem_pkg::MEM_SRC_HOST};
            default: ;
         endcase
         // a host response that lost waits its turn, dropped when the queue is full
         if (host_rsp_v_i && pick != 3 && hostq_m.size() < `BRIDGE_HOSTQ_DEPTH)
            hostq_m.push_back(host_rsp_i);
      end

      if (rst_i)
      begin
         ctrl_m = '0;
         base_m = '0;
      end
      else if (csr_cmd_v_i && csr_cmd_i.we)
      begin
         if (csr_cmd_i.addr == csr_pkg::CSR_CTRL)
            ctrl_m = csr_cmd_i.wdata;
         else if (csr_cmd_i.addr == csr_pkg::CSR_DRAM_BASE)
            base_m = csr_cmd_i.wdata;
      end

      idle_o = !exp_rd_v && !exp_host_v && !exp_dram_v && !exp_rsp_v && hostq_m.size() == 0;
      hostq_level_o = hostq_m.size();
   endtask

   initial
   begin
      checks_o      = 0;
      errors_o      = 0;
      idle_o        = 1'b1;
      hostq_level_o = 0;
      ctrl_m        = '0;
      base_m        = '0;
      credits_m     = '0;
      exp_rd_v      = 1'b0;
      exp_host_v    = 1'b0;
      exp_dram_v    = 1'b0;
      exp_rsp_v     = 1'b0;
   end

   // inputs and registered outputs are both settled at the falling edge
   always @(negedge aclk_i)
   begin
      compare("register read", exp_rd_v, csr_rd_v_i, 65'(exp_rd), 65'(csr_rd_data_i));
      compare("host request", exp_host_v, host_req_v_i, 65'(exp_host), 65'(host_req_i));
      compare("dram request", exp_dram_v, dram_req_v_i, 65'(exp_dram), 65'(dram_req_i));
      compare("processor response", exp_rsp_v, proc_rsp_v_i, 65'(exp_rsp), 65'(proc_rsp_i));
      predict();
   end

endmodule

`default_nettype wire

/* bench/bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module bridge_tb;

   localparam int route_n  = 150;
   localparam int credit_n = 60;
   localparam int merge_n  = 300;
   // reset, register and saturation sequences, reads and drains, then margin
   localparam int run_cycles = 8 + 100 + route_n + credit_n + merge_n + 500;

   typedef logic [`BRIDGE_TILE_W-1:0] tile_t;
   typedef logic [`BRIDGE_DEV_W-1:0]  dev_t;

   logic               aclk_i = 1'b0;
   logic               rst_i;
   logic               csr_cmd_v_i;
   csr_pkg::csr_cmd_s  csr_cmd_i;
   logic               csr_rd_v_o;
   csr_pkg::csr_data_t csr_rd_data_o;
   logic               proc_req_v_i;
   mem_pkg::mem_req_s  proc_req_i;
   logic               proc_rsp_v_o;
   mem_pkg::mem_rsp_s  proc_rsp_o;
   logic               host_req_v_o;
   mem_pkg::mem_req_s  host_req_o;
   logic               host_rsp_v_i;
   mem_pkg::word_t     host_rsp_i;
   logic               dram_req_v_o;
   mem_pkg::mem_req_s  dram_req_o;
   logic               dram_rsp_v_i;
   mem_pkg::word_t     dram_rsp_i;

   logic [2:0]         test_id;
   logic               chk_idle;
   int                 checks;
   int                 errors;
   int                 hostq_level;
   int                 fails;
   int                 last_checks;
   int                 last_errors;
   logic [31:0]        lfsr_q;

   zynq_bridge_top uut (.*);

   bridge_checker chk
     (.aclk_i(aclk_i)
      ,.rst_i(rst_i)
      ,.test_id_i(test_id)
      ,.csr_cmd_v_i(csr_cmd_v_i)
      ,.csr_cmd_i(csr_cmd_i)
      ,.csr_rd_v_i(csr_rd_v_o)
      ,.csr_rd_data_i(csr_rd_data_o)
      ,.proc_req_v_i(proc_req_v_i)
      ,.proc_req_i(proc_req_i)
      ,.host_req_v_i(host_req_v_o)
      ,.host_req_i(host_req_o)
      ,.dram_req_v_i(dram_req_v_o)
      ,.dram_req_i(dram_req_o)
      ,.host_rsp_v_i(host_rsp_v_i)
      ,.host_rsp_i(host_rsp_i)
      ,.dram_rsp_v_i(dram_rsp_v_i)
      ,.dram_rsp_i(dram_rsp_i)
      ,.proc_rsp_v_i(proc_rsp_v_o)
      ,.proc_rsp_i(proc_rsp_o)
      ,.checks_o(checks)
      ,.errors_o(errors)
      ,.idle_o(chk_idle)
      ,.hostq_level_o(hostq_level)
      );

   //////////////////////////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////////////////////////

   // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         v      = {v[30:0], fb};
      end
      return v;
   endfunction

   // 0 host device, 1 some local device, 2 dram space, 3 anything
   function automatic mem_pkg::paddr_t make_addr(logic [31:0] kind);
      mem_pkg::paddr_t a;
      a = rand_bits(32);
      if (kind[1:0] != 2'd3)
         a[31] = (kind[1:0] == 2'd2);
      if (kind[1:0] < 2'd2)
         a[`BRIDGE_TILE_LSB +: `BRIDGE_TILE_W] = tile_t'(`BRIDGE_MY_TILE);
      if (kind[1:0] == 2'd0)
         a[`BRIDGE_DEV_LSB +: `BRIDGE_DEV_W] = dev_t'(`BRIDGE_HOST_DEV);
      return a;
   endfunction

   task automatic step();
      @(posedge aclk_i);
      #1;
      csr_cmd_v_i  = 1'b0;
      proc_req_v_i = 1'b0;
      host_rsp_v_i = 1'b0;
      dram_rsp_v_i = 1'b0;
   endtask

   task automatic set_request(logic [31:0] kind);
      proc_req_v_i    = 1'b1;
      proc_req_i.addr = make_addr(kind);
      proc_req_i.data = rand_bits(32);
      proc_req_i.we   = (rand_bits(1) != 0);
   endtask

   task automatic set_host_rsp();
      host_rsp_v_i = 1'b1;
      host_rsp_i   = rand_bits(32);
   endtask

   task automatic csr_write(csr_pkg::csr_addr_t idx, csr_pkg::csr_data_t val);
      csr_cmd_v_i = 1'b1;
      csr_cmd_i   = '{addr: idx, we: 1'b1, wdata: val};
      step();
   endtask

   task automatic csr_read(csr_pkg::csr_addr_t idx);
      int wait_n;
      csr_cmd_v_i = 1'b1;
      csr_cmd_i   = '{addr: idx, we: 1'b0, wdata: '0};
      step();
      wait_n = 0;
      while (!csr_rd_v_o && wait_n < 4)
      begin
         step();
         wait_n++;
      end
      if (!csr_rd_v_o)
      begin
         fails++;
         $display("no read response for register %0d", idx);
      end
      step();
   endtask

   // let the pipeline empty, then report the test
   task automatic finish_test(string name);
      int wait_n;
      wait_n = 0;
      step();
      while (!chk_idle && wait_n < 20)
      begin
         step();
         wait_n++;
      end
      if (!chk_idle)
      begin
         fails++;
         $display("test %s: outputs still pending after the stimulus ended", name);
      end
      $display("test %-16s %0d checks, %0d errors", name,
               checks - last_checks, errors - last_errors);
      last_checks = checks;
      last_errors = errors;
   endtask

   //////////////////////////////////////////////////////////////////////
   // clock, watchdog and test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      forever #5 aclk_i = ~aclk_i;
   end

   initial
   begin
      #(run_cycles * 10);
      $display("watchdog expired after %0d cycles, the run hung", run_cycles);
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      rst_i        = 1'b1;
      csr_cmd_v_i  = 1'b0;
      csr_cmd_i    = '0;
      proc_req_v_i = 1'b0;
      proc_req_i   = '0;
      host_rsp_v_i = 1'b0;
      host_rsp_i   = '0;
      dram_rsp_v_i = 1'b0;
      dram_rsp_i   = '0;
      test_id      = 3'd0;
      fails        = 0;
      last_checks  = 0;
      last_errors  = 0;
      lfsr_q       = 32'h3598_b4bc;
      repeat (8) @(posedge aclk_i);
      #1;
      rst_i = 1'b0;

      test_id = 3'd1;
      csr_write(csr_pkg::CSR_DRAM_BASE, rand_bits(32));
      csr_read(csr_pkg::CSR_DRAM_BASE);
      csr_write(csr_pkg::CSR_CTRL, rand_bits(32) | 32'h1);
      csr_read(csr_pkg::CSR_CTRL);
      csr_read(4'd3);
      csr_read(4'd15);
      csr_write(csr_pkg::CSR_CREDITS, 32'hffff_ffff);
      csr_read(csr_pkg::CSR_CREDITS);
      finish_test("register_access");

      // outstanding host credits give the soft reset something to clear
      test_id = 3'd2;
      repeat (3)
      begin
         set_request(0);
         step();
      end
      // datapath held while ctrl bit 0 is low
      csr_write(csr_pkg::CSR_CTRL, 32'h0);
      repeat (10)
      begin
         set_request(rand_bits(2));
         step();
      end
      csr_read(csr_pkg::CSR_CREDITS);
      csr_write(csr_pkg::CSR_CTRL, 32'h1);
      repeat (10)
      begin
         set_request(rand_bits(2));
         step();
      end
      finish_test("soft_reset");

      test_id = 3'd3;
      csr_write(csr_pkg::CSR_DRAM_BASE, rand_bits(32));
      repeat (route_n)
      begin
         if (rand_bits(2) != 0)
            set_request(rand_bits(2));
         step();
      end
      finish_test("routing");

      // fill past the limit, drain past zero, then mix
      test_id = 3'd4;
      repeat (40)
      begin
         set_request(0);
         step();
      end
      csr_read(csr_pkg::CSR_CREDITS);
      repeat (12)
      begin
         set_host_rsp();
         step();
      end
      csr_read(csr_pkg::CSR_CREDITS);
      repeat (45)
      begin
         set_host_rsp();
         step();
      end
      csr_read(csr_pkg::CSR_CREDITS);
      repeat (credit_n)
      begin
         if (rand_bits(1) != 0)
            set_request(0);
         if (rand_bits(1) != 0)
            set_host_rsp();
         step();
      end
      csr_read(csr_pkg::CSR_CREDITS);
      finish_test("credits");

      // dense dram traffic so host responses pile up in the queue
      test_id = 3'd5;
      repeat (merge_n)
      begin
         if (rand_bits(2) != 0)
         begin
            dram_rsp_v_i = 1'b1;
            dram_rsp_i   = rand_bits(32);
         end
         if (rand_bits(1) != 0 && hostq_level < `BRIDGE_HOSTQ_DEPTH)
            set_host_rsp();
         step();
      end
      finish_test("response_merge");

      $display("done: %0d checks, %0d errors, %0d other failures", checks, errors, fails);
      if (errors == 0 && fails == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hdl
hdl/csr_pkg.sv
hdl/mem_pkg.sv
hdl/csr_bank.sv
hdl/mem_fwd_router.sv
hdl/host_credit_tracker.sv
hdl/mem_rev_merge.sv
hdl/zynq_bridge_top.sv
bench/bridge_checker.sv
bench/bridge_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := bridge_tb
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
